// ==== common/ccPkg.sv ====
package ccPkg;

    // Graph geometry: one bit per node of the 7-dimensional subset lattice
    localparam int GraphWidth = 128;
    localparam int IndexBits = 7;

    // Result and caller tag widths
    localparam int CountWidth = 8;
    localparam int TagWidth = 10;

    // Grouping used by the lowest-bit search
    localparam int NibbleCount = GraphWidth / 4;
    localparam int GroupCount = GraphWidth / 16;

    typedef logic [GraphWidth-1:0] graphT;
    typedef logic [CountWidth-1:0] countT;
    typedef logic [TagWidth-1:0] tagT;

    // One job as handed over on the job port
    typedef struct packed {
        graphT graph;
        tagT tag;
    } jobT;

    // One result as handed back on the result port
    typedef struct packed {
        countT count;
        tagT tag;
    } resultT;

    // Master-to-slave side of the Wishbone job port
    typedef struct packed {
        logic cyc;
        logic stb;
        jobT dat;
    } jobBusReqT;

    // Master-to-slave side of the Wishbone result port
    typedef struct packed {
        logic cyc;
        logic stb;
        resultT dat;
    } resultBusReqT;

    typedef enum logic [1:0] {
        Idle,
        Seed,
        Explore,
        Report
    } counterStateT;

endpackage

// ==== explore/explorationStep.sv ====
module explorationStep (
    input  logic         clk,
    input  logic         arstN,
    input  logic         start,
    input  ccPkg::graphT cur,
    input  ccPkg::graphT remaining,
    output ccPkg::graphT extended,
    output ccPkg::graphT reduced,
    output logic         finished,
    output logic         doneStep
);
    import ccPkg::*;

    graphT upClosed;
    graphT downClosed;
    graphT midSet;
    graphT remainingD1;
    graphT remainingD2;
    graphT curD1;
    graphT curD2;
    logic startD1;
    logic startD2;

    latticeClosure #(.Upward(1'b1)) u_upClosure (
        .clk   (clk),
        .arstN (arstN),
        .graph (cur),
        .closed(upClosed)
    );

    // Only upper nodes that are still in the graph can join the component
    assign midSet = upClosed & remainingD1;

    latticeClosure #(.Upward(1'b0)) u_downClosure (
        .clk   (clk),
        .arstN (arstN),
        .graph (midSet),
        .closed(downClosed)
    );

    always_ff @(posedge clk) begin
        remainingD1 <= remaining;
        remainingD2 <= remainingD1;
        curD1 <= cur;
        curD2 <= curD1;
        extended <= remainingD2 & downClosed;
        reduced <= remainingD2 & ~downClosed;
        // No growth in this round means the component is complete
        finished <= (remainingD2 & downClosed) == curD2;
    end

    // Valid travels with the data so rounds may overlap
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            startD1 <= 1'b0;
            startD2 <= 1'b0;
            doneStep <= 1'b0;
        end else begin
            startD1 <= start;
            startD2 <= startD1;
            doneStep <= startD2;
        end
    end

endmodule

// ==== explore/latticeClosure.sv ====
module latticeClosure #(
    parameter bit Upward = 1'b1
) (
    input  logic         clk,
    input  logic         arstN,
    input  ccPkg::graphT graph,
    output ccPkg::graphT closed
);
    import ccPkg::*;

    graphT closedNext;

    // One pass per dimension. Within a pass the neighbor bit is never
    // the one being updated, so the update can be done in place
    always_comb begin
        graphT level;
        level = graph;
        for (int d = 0; d < IndexBits; d++) begin
            for (int i = 0; i < GraphWidth; i++) begin
                // Up: index with bit d set pulls from the one below
                // Down: index with bit d clear pulls from the one above
                if (i[d] == Upward) begin
                    level[i] = level[i] | level[i ^ (1 << d)];
                end
            end
        end
        closedNext = level;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            closed <= '0;
        end else begin
            closed <= closedNext;
        end
    end

endmodule

// ==== hdl/componentCounter.sv ====
module componentCounter (
    input  logic                clk,
    input  logic                arstN,
    input  ccPkg::jobBusReqT    jobReq,
    output logic                jobAck,
    output ccPkg::resultBusReqT resultReq,
    input  logic                resultAck
);
    import ccPkg::*;

    counterStateT state;
    graphT remaining;
    graphT remainingNext;
    graphT cur;
    graphT seed;
    graphT extended;
    graphT reduced;
    countT count;
    tagT tag;
    logic empty;
    logic finished;
    logic doneStep;
    logic stepStart;
    logic reportValid;

    // The finder sees the value remaining is about to take, so its
    // registered answer is ready in the Seed cycle
    always_comb begin
        remainingNext = remaining;
        if (state == Idle && jobAck) begin
            remainingNext = jobReq.dat.graph;
        end else if (state == Explore && doneStep && finished) begin
            remainingNext = reduced;
        end
    end

    seedSelector u_seedSelector (
        .clk      (clk),
        .arstN    (arstN),
        .remaining(remainingNext),
        .seed     (seed),
        .empty    (empty)
    );

    explorationStep u_step (
        .clk      (clk),
        .arstN    (arstN),
        .start    (stepStart),
        .cur      (cur),
        .remaining(remaining),
        .extended (extended),
        .reduced  (reduced),
        .finished (finished),
        .doneStep (doneStep)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= Idle;
            jobAck <= 1'b0;
            stepStart <= 1'b0;
            reportValid <= 1'b0;
        end else begin
            jobAck <= 1'b0;
            stepStart <= 1'b0;
            case (state)
                Idle: begin
                    // Ack for one cycle, the job is taken on the ack edge
                    if (jobAck) begin
                        state <= Seed;
                    end else if (jobReq.cyc && jobReq.stb) begin
                        jobAck <= 1'b1;
                    end
                end
                Seed: begin
                    if (empty) begin
                        state <= Report;
                        reportValid <= 1'b1;
                    end else begin
                        state <= Explore;
                        stepStart <= 1'b1;
                    end
                end
                Explore: begin
                    if (doneStep) begin
                        if (finished) begin
                            state <= Seed;
                        end else begin
                            stepStart <= 1'b1;
                        end
                    end
                end
                Report: begin
                    if (resultAck) begin
                        reportValid <= 1'b0;
                        state <= Idle;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    // Job payload
    always_ff @(posedge clk) begin
        remaining <= remainingNext;
        case (state)
            Idle: begin
                if (jobAck) begin
                    count <= '0;
                    tag <= jobReq.dat.tag;
                end
            end
            Seed: begin
                if (!empty) begin
                    count <= count + countT'(1);
                    cur <= seed;
                end
            end
            Explore: begin
                if (doneStep && !finished) begin
                    cur <= extended;
                end
            end
            default: ;
        endcase
    end

    // Count and tag do not change while in Report, so dat holds under back-pressure
    always_comb begin
        resultReq.cyc = reportValid;
        resultReq.stb = reportValid;
        resultReq.dat.count = count;
        resultReq.dat.tag = tag;
    end

endmodule

// ==== hdl/connectedCountTop.sv ====
module connectedCountTop (
    input  logic                clk,
    input  logic                arstN,
    input  ccPkg::jobBusReqT    jobReq,
    output logic                jobAck,
    output ccPkg::resultBusReqT resultReq,
    input  logic                resultAck
);
    import ccPkg::*;

    componentCounter u_counter (
        .clk      (clk),
        .arstN    (arstN),
        .jobReq   (jobReq),
        .jobAck   (jobAck),
        .resultReq(resultReq),
        .resultAck(resultAck)
    );

endmodule

// ==== hdl/firstBitFinder.sv ====
module firstBitFinder (
    input  logic         clk,
    input  logic         arstN,
    input  ccPkg::graphT graph,
    output ccPkg::graphT firstBit,
    output logic         isEmpty
);
    import ccPkg::*;

    logic [NibbleCount-1:0] hasBit4;
    logic [GroupCount-1:0] hasBit16;
    // groupClear[g] is high when every group below g is empty
    logic [GroupCount:0] groupClear;
    graphT firstBitNext;

    always_comb begin
        logic nibbleClear;
        logic bitClear;
        for (int n = 0; n < NibbleCount; n++) begin
            hasBit4[n] = |graph[4*n +: 4];
        end
        for (int g = 0; g < GroupCount; g++) begin
            hasBit16[g] = |hasBit4[4*g +: 4];
        end
        groupClear[0] = 1'b1;
        for (int g = 0; g < GroupCount; g++) begin
            groupClear[g+1] = groupClear[g] & ~hasBit16[g];
        end
        firstBitNext = '0;
        for (int g = 0; g < GroupCount; g++) begin
            // Only the first non-empty group contributes
            nibbleClear = groupClear[g] & hasBit16[g];
            for (int k = 0; k < 4; k++) begin
                bitClear = nibbleClear & hasBit4[4*g+k];
                if (bitClear) begin
                    nibbleClear = 1'b0;
                end
                for (int b = 0; b < 4; b++) begin
                    if (bitClear && graph[16*g+4*k+b]) begin
                        firstBitNext[16*g+4*k+b] = 1'b1;
                        bitClear = 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            firstBit <= '0;
            isEmpty <= 1'b1;
        end else begin
            firstBit <= firstBitNext;
            isEmpty <= groupClear[GroupCount];
        end
    end

endmodule

// ==== hdl/seedSelector.sv ====
module seedSelector (
    input  logic         clk,
    input  logic         arstN,
    input  ccPkg::graphT remaining,
    output ccPkg::graphT seed,
    output logic         empty
);
    import ccPkg::*;

    graphT firstBit;
    graphT remainingD;

    firstBitFinder u_finder (
        .clk     (clk),
        .arstN   (arstN),
        .graph   (remaining),
        .firstBit(firstBit),
        .isEmpty (empty)
    );

    // Keep the graph in step with the registered one-hot mask
    always_ff @(posedge clk) begin
        remainingD <= remaining;
    end

    assign seed = firstBit & remainingD;

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module connectedCountTb -f src.f -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "^ALL CHECKS PASSED$" sim.log; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: simulation failed"
    exit 1
fi

// ==== src.f ====
common/ccPkg.sv
hdl/firstBitFinder.sv
hdl/seedSelector.sv
explore/latticeClosure.sv
explore/explorationStep.sv
hdl/componentCounter.sv
hdl/connectedCountTop.sv
verif/clockGen.sv
verif/connectedCountAssertions.sv
verif/connectedCountTb.sv

// ==== verif/clockGen.sv ====
module clockGen (
    output logic clk,
    output logic arstN
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HalfPeriod = 10;
    localparam int ResetCycles = 16;

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        // Release on a falling edge, away from the sampling edge
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

// ==== verif/connectedCountAssertions.sv ====
module connectedCountAssertions (
    input logic                clk,
    input logic                arstN,
    input ccPkg::jobBusReqT    jobReq,
    input logic                jobAck,
    input ccPkg::resultBusReqT resultReq,
    input logic                resultAck
);
    timeunit 1ns;
    timeprecision 1ps;
    import ccPkg::*;

    int failCount = 0;

    // Result payload holds while the slave stalls
    resultHeld: assert property (@(posedge clk) disable iff (!arstN)
        resultReq.stb && !resultAck |=> $stable(resultReq.dat))
    else begin
        $error("resultReq.dat changed while stb waited for ack");
        failCount++;
    end

    // Ack only answers a request seen on the previous edge
    ackAnswersRequest: assert property (@(posedge clk) disable iff (!arstN)
        $rose(jobAck) |-> $past(jobReq.cyc && jobReq.stb))
    else begin
        $error("jobAck rose without jobReq cyc and stb");
        failCount++;
    end

    // Strobe and cycle stay up until the slave acks
    strobeInCycle: assert property (@(posedge clk) disable iff (!arstN)
        resultReq.stb && !resultAck |=> resultReq.stb && resultReq.cyc)
    else begin
        $error("resultReq stb or cyc dropped before ack");
        failCount++;
    end

    quietInReset: assert property (@(posedge clk)
        !arstN && $past(!arstN) |-> !jobAck && !resultReq.stb)
    else begin
        $error("bus outputs active during reset");
        failCount++;
    end

endmodule

// ==== verif/connectedCountTb.sv ====
module connectedCountTb;
    timeunit 1ns;
    timeprecision 1ps;
    import ccPkg::*;

    // Cycles allowed for any single wait
    localparam int Timeout = 5000;

    logic clk;
    logic arstN;
    jobBusReqT jobReq;
    logic jobAck;
    resultBusReqT resultReq;
    logic resultAck;
    int valueErrors;
    int otherErrors;

    clockGen u_clockGen (
        .clk  (clk),
        .arstN(arstN)
    );

    connectedCountTop u_connectedCountTop (
        .clk      (clk),
        .arstN    (arstN),
        .jobReq   (jobReq),
        .jobAck   (jobAck),
        .resultReq(resultReq),
        .resultAck(resultAck)
    );

    bind componentCounter connectedCountAssertions u_assertions (
        .clk      (clk),
        .arstN    (arstN),
        .jobReq   (jobReq),
        .jobAck   (jobAck),
        .resultReq(resultReq),
        .resultAck(resultAck)
    );

    // Brute force over index pairs, straight from the component rule
    function automatic countT refCount(input graphT graph);
        graphT rest;
        graphT comp;
        graphT prev;
        graphT upper;
        countT n;
        logic found;
        rest = graph;
        n = '0;
        while (rest != '0) begin
            comp = '0;
            found = 1'b0;
            for (int i = 0; i < GraphWidth; i++) begin
                if (rest[i] && !found) begin
                    comp[i] = 1'b1;
                    found = 1'b1;
                end
            end
            n = n + countT'(1);
            do begin
                prev = comp;
                upper = '0;
                for (int j = 0; j < GraphWidth; j++) begin
                    for (int i = 0; i < GraphWidth; i++) begin
                        if (comp[i] && (i & j) == i) upper[j] = 1'b1;
                    end
                end
                upper = upper & rest;
                comp = '0;
                for (int j = 0; j < GraphWidth; j++) begin
                    for (int i = 0; i < GraphWidth; i++) begin
                        if (upper[i] && (i & j) == j) comp[j] = 1'b1;
                    end
                end
                comp = comp & rest;
            end while (comp != prev);
            rest = rest & ~comp;
        end
        return n;
    endfunction

    function automatic graphT randomGraph();
        graphT graph;
        for (int w = 0; w < GraphWidth / 32; w++) begin
            graph[32*w +: 32] = $urandom;
        end
        return graph;
    endfunction

    task automatic checkCount(input string name, input countT expected, input countT actual);
        if (actual !== expected) begin
            $display("FAILED %s: count expected %0d, actual %0d", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkTag(input string name, input tagT expected, input tagT actual);
        if (actual !== expected) begin
            $display("FAILED %s: tag expected 0x%03h, actual 0x%03h", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic reportProblem(input string what);
        $display("ERROR: %s", what);
        otherErrors++;
    endtask

    task automatic presentJob(input graphT graph, input tagT tag);
        jobReq.cyc = 1'b1;
        jobReq.stb = 1'b1;
        jobReq.dat.graph = graph;
        jobReq.dat.tag = tag;
    endtask

    task automatic releaseJob();
        jobReq.cyc = 1'b0;
        jobReq.stb = 1'b0;
    endtask

    // Returns on the falling edge after the transfer edge
    task automatic waitJobAck(input string name, output logic ok);
        int cycles;
        cycles = 0;
        while (!jobAck && cycles < Timeout) begin
            @(negedge clk);
            cycles++;
        end
        ok = jobAck;
        if (ok) begin
            @(negedge clk);
        end else begin
            reportProblem($sformatf("%s: no jobAck within %0d cycles", name, Timeout));
        end
    endtask

    task automatic awaitResult(input string name, output logic ok);
        int cycles;
        cycles = 0;
        while (!resultReq.stb && cycles < Timeout) begin
            @(negedge clk);
            cycles++;
        end
        ok = resultReq.stb;
        if (!ok) begin
            reportProblem($sformatf("%s: no result strobe within %0d cycles", name, Timeout));
        end else if (!resultReq.cyc) begin
            reportProblem($sformatf("%s: result strobe raised without cyc", name));
        end
    endtask

    // Called while the strobe is high, acks for one cycle
    task automatic takeResult(output resultT result);
        result = resultReq.dat;
        resultAck = 1'b1;
        @(negedge clk);
        resultAck = 1'b0;
    endtask

    task automatic runJob(input string name, input graphT graph, input tagT tag,
                          input countT expected);
        logic ok;
        resultT result;
        presentJob(graph, tag);
        waitJobAck(name, ok);
        releaseJob();
        if (ok) begin
            awaitResult(name, ok);
            if (ok) begin
                takeResult(result);
                checkCount(name, expected, result.count);
                checkTag(name, tag, result.tag);
            end
        end
    endtask

    task automatic emptyGraph();
        runJob("emptyGraph", '0, 10'h2A5, 8'd0);
    endtask

    task automatic singleBits();
        graphT graph;
        int idx;
        idx = $urandom % GraphWidth;
        graph = '0;
        graph[idx] = 1'b1;
        runJob($sformatf("singleBit%0d", idx), graph, tagT'(idx), 8'd1);
        graph = '0;
        graph[0] = 1'b1;
        runJob("bitZero", graph, 10'h001, 8'd1);
    endtask

    task automatic knownGraphs();
        graphT graph;
        // Nodes 1 and 2 share no upper node inside the set
        graph = '0;
        graph[1] = 1'b1;
        graph[2] = 1'b1;
        runJob("bits1And2", graph, 10'h012, 8'd2);
        graph[3] = 1'b1;
        runJob("bits1To3", graph, 10'h013, 8'd1);
        graph[3] = 1'b0;
        graph[127] = 1'b1;
        runJob("bits1And2And127", graph, 10'h07F, 8'd1);
    endtask

    task automatic randomSparseGraphs();
        graphT graph;
        for (int t = 0; t < 40; t++) begin
            graph = randomGraph() & randomGraph();
            runJob($sformatf("randomSparse%0d", t), graph, tagT'($urandom), refCount(graph));
        end
    endtask

    task automatic backPressure();
        graphT firstGraph;
        graphT secondGraph;
        resultT held;
        resultT result;
        logic ok;
        int holdCycles;
        firstGraph = randomGraph() & randomGraph();
        secondGraph = randomGraph() & randomGraph();
        holdCycles = 1 + $urandom % 20;
        presentJob(firstGraph, 10'h155);
        waitJobAck("backPressure", ok);
        releaseJob();
        if (ok) awaitResult("backPressure", ok);
        if (ok) begin
            held = resultReq.dat;
            presentJob(secondGraph, 10'h0AA);
            for (int k = 0; k < holdCycles; k++) begin
                @(negedge clk);
                if (!resultReq.stb) reportProblem("backPressure: result strobe dropped early");
                if (jobAck) reportProblem("backPressure: second job acked during a stall");
                checkCount("backPressureHold", held.count, resultReq.dat.count);
                checkTag("backPressureHold", held.tag, resultReq.dat.tag);
            end
            takeResult(result);
            checkCount("backPressureFirst", refCount(firstGraph), result.count);
            checkTag("backPressureFirst", 10'h155, result.tag);
            waitJobAck("backPressureSecond", ok);
        end
        releaseJob();
        if (ok) awaitResult("backPressureSecond", ok);
        if (ok) begin
            takeResult(result);
            checkCount("backPressureSecond", refCount(secondGraph), result.count);
            checkTag("backPressureSecond", 10'h0AA, result.tag);
        end
    endtask

    // Next job is presented as soon as the previous one is taken
    task automatic backToBackJobs();
        graphT graphs[4];
        tagT tags[4];
        resultT result;
        logic ok;
        for (int i = 0; i < 4; i++) begin
            graphs[i] = randomGraph() & randomGraph();
            tags[i] = tagT'(10'h300 + i);
        end
        presentJob(graphs[0], tags[0]);
        waitJobAck("backToBack0", ok);
        for (int i = 0; i < 4 && ok; i++) begin
            if (i + 1 < 4) presentJob(graphs[i+1], tags[i+1]);
            else releaseJob();
            awaitResult($sformatf("backToBack%0d", i), ok);
            if (ok) begin
                takeResult(result);
                checkCount($sformatf("backToBack%0d", i), refCount(graphs[i]), result.count);
                checkTag($sformatf("backToBack%0d", i), tags[i], result.tag);
                if (i + 1 < 4) waitJobAck($sformatf("backToBack%0d", i + 1), ok);
            end
        end
        releaseJob();
    endtask

    initial begin
        int cycles;
        jobReq = '0;
        resultAck = 1'b0;
        valueErrors = 0;
        otherErrors = 0;
        void'($urandom(60498));
        cycles = 0;
        while (arstN !== 1'b1 && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (arstN !== 1'b1) begin
            reportProblem("reset was never released");
        end else begin
            if (jobAck || resultReq.stb) reportProblem("bus outputs active right after reset");
            emptyGraph();
            singleBits();
            knownGraphs();
            randomSparseGraphs();
            backPressure();
            backToBackJobs();
        end
        otherErrors += u_connectedCountTop.u_counter.u_assertions.failCount;
        $display("Closing: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
